// ==== flist.f ====
sparam_pkg.sv
seq_divider.sv
sample_accumulator.sv
sparam_sequencer.sv
sparam_averager_top.sv
sparam_properties.sv
tb_sparam_averager.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_sparam_averager \
    -o sim_tb_sparam_averager

./obj_dir/sim_tb_sparam_averager

// ==== tb_sparam_averager.sv ====
module tb_sparam_averager import sparam_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 3;
    localparam int NUM_RUNS       = 3;
    localparam int BLOCKS_PER_RUN = 8;
    localparam int MAX_SAMPLES    = 8;
    localparam int MAX_GAP        = 3;
    localparam int MAX_STALL      = 15;
    localparam int BLOCK_CYCLES   = MAX_SAMPLES * (MAX_GAP + 1) + 120 + MAX_STALL;
    localparam longint WATCHDOG_TIME =
        longint'(NUM_RUNS) * BLOCKS_PER_RUN * BLOCK_CYCLES * CLK_PERIOD;

    localparam int MODE_NORMAL  = 0;
    localparam int MODE_ZERO_A1 = 1;
    localparam int MODE_WRAP    = 2;

    logic        clk_in;
    logic        rst_in;
    logic [15:0] num_samples;
    logic        in_valid;
    wave_set_t   in_sample;
    logic        out_ready;
    logic        in_ready;
    logic        out_valid;
    sparam_set_t out_sparams;

    block_sums_t model_sums;
    logic [15:0] lfsr_state;

    sparam_averager_top sparam_averager_top_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .num_samples (num_samples),
        .in_valid    (in_valid),
        .in_sample   (in_sample),
        .out_ready   (out_ready),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_sparams (out_sparams)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before all blocks were processed");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [COEFF_W-1:0] random_angle(input logic high_half);
        logic [31:0] r;
        r = random_bits(COEFF_W - 1);
        return {high_half, r[COEFF_W-2:0]};
    endfunction

    task automatic make_sample(input int mode, output wave_set_t w);
        // wrap mode puts a angles in the upper half and b angles in the lower
        w.a1.angle  = random_angle((mode == MODE_WRAP) ? 1'b1 : 1'(random_bits(1)));
        w.b1.angle  = random_angle((mode == MODE_WRAP) ? 1'b0 : 1'(random_bits(1)));
        w.a2.angle  = random_angle((mode == MODE_WRAP) ? 1'b1 : 1'(random_bits(1)));
        w.b2.angle  = random_angle((mode == MODE_WRAP) ? 1'b0 : 1'(random_bits(1)));
        w.a1.radius = (mode == MODE_ZERO_A1) ? '0 : COEFF_W'(random_bits(COEFF_W));
        w.b1.radius = COEFF_W'(random_bits(COEFF_W));
        w.a2.radius = COEFF_W'(random_bits(COEFF_W));
        w.b2.radius = COEFF_W'(random_bits(COEFF_W));
    endtask

    task automatic model_add(input wave_set_t w);
        logic [COEFF_W-1:0] d11;
        logic [COEFF_W-1:0] d12;
        logic [COEFF_W-1:0] d21;
        logic [COEFF_W-1:0] d22;
        // 16-bit subtraction wraps modulo 2^16
        d11 = w.b1.angle - w.a1.angle;
        d12 = w.b1.angle - w.a2.angle;
        d21 = w.b2.angle - w.a1.angle;
        d22 = w.b2.angle - w.a2.angle;
        model_sums.rad_a1  = model_sums.rad_a1 + {16'h0000, w.a1.radius};
        model_sums.rad_b1  = model_sums.rad_b1 + {16'h0000, w.b1.radius};
        model_sums.rad_a2  = model_sums.rad_a2 + {16'h0000, w.a2.radius};
        model_sums.rad_b2  = model_sums.rad_b2 + {16'h0000, w.b2.radius};
        model_sums.ang_s11 = model_sums.ang_s11 + {16'h0000, d11};
        model_sums.ang_s12 = model_sums.ang_s12 + {16'h0000, d12};
        model_sums.ang_s21 = model_sums.ang_s21 + {16'h0000, d21};
        model_sums.ang_s22 = model_sums.ang_s22 + {16'h0000, d22};
    endtask

    function automatic sparam_t expect_param(input logic [ACC_W-1:0] ang_sum,
                                             input logic [ACC_W-1:0] b_sum,
                                             input logic [ACC_W-1:0] a_sum,
                                             input logic [ACC_W-1:0] n);
        sparam_t          p;
        logic [ACC_W-1:0] phase_mean;
        logic [ACC_W-1:0] mean_a;
        logic [ACC_W-1:0] mean_b;
        logic [63:0]      scaled;
        logic [63:0]      ratio;
        phase_mean = ang_sum / n;
        mean_a     = a_sum / n;
        mean_b     = b_sum / n;
        scaled     = {32'h0000_0000, mean_b} << RATIO_FRAC_BITS;
        p.phase    = phase_mean[COEFF_W-1:0];
        if (mean_a == '0) begin
            p.mag = '0;
        end else begin
            // full-width quotient, then truncated to the output width
            ratio = scaled / {32'h0000_0000, mean_a};
            p.mag = ratio[ACC_W-1:0];
        end
        return p;
    endfunction

    function automatic sparam_set_t expect_result(input block_sums_t s, input logic [15:0] n);
        sparam_set_t      e;
        logic [ACC_W-1:0] d;
        d     = {16'h0000, n};
        e.s11 = expect_param(s.ang_s11, s.rad_b1, s.rad_a1, d);
        e.s12 = expect_param(s.ang_s12, s.rad_b1, s.rad_a2, d);
        e.s21 = expect_param(s.ang_s21, s.rad_b2, s.rad_a1, d);
        e.s22 = expect_param(s.ang_s22, s.rad_b2, s.rad_a2, d);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_handshake(input logic exp_in_ready, input logic exp_out_valid);
        check_value("in_ready", 64'(in_ready), 64'(exp_in_ready));
        check_value("out_valid", 64'(out_valid), 64'(exp_out_valid));
    endtask

    task automatic check_sparams(input sparam_set_t e);
        check_value("out_sparams.s11.phase", 64'(out_sparams.s11.phase), 64'(e.s11.phase));
        check_value("out_sparams.s11.mag", 64'(out_sparams.s11.mag), 64'(e.s11.mag));
        check_value("out_sparams.s12.phase", 64'(out_sparams.s12.phase), 64'(e.s12.phase));
        check_value("out_sparams.s12.mag", 64'(out_sparams.s12.mag), 64'(e.s12.mag));
        check_value("out_sparams.s21.phase", 64'(out_sparams.s21.phase), 64'(e.s21.phase));
        check_value("out_sparams.s21.mag", 64'(out_sparams.s21.mag), 64'(e.s21.mag));
        check_value("out_sparams.s22.phase", 64'(out_sparams.s22.phase), 64'(e.s22.phase));
        check_value("out_sparams.s22.mag", 64'(out_sparams.s22.mag), 64'(e.s22.mag));
    endtask

    task automatic apply_reset(input logic [15:0] n);
        @(negedge clk_in);
        rst_in      = 1'b1;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        num_samples = n;
        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;
        check_handshake(1'b1, 1'b0);
    endtask

    // one sample is taken on the posedge after a negedge that sees in_ready
    task automatic send_sample(input int mode);
        wave_set_t w;
        int        gap;
        make_sample(mode, w);
        gap = 0;
        if (random_bits(2) == '0) begin
            gap = 1 + int'(random_bits(1));
        end
        repeat (gap) begin
            @(negedge clk_in);
            in_valid  = 1'b0;
            in_sample = ~w;
        end
        do begin
            @(negedge clk_in);
            in_valid  = 1'b1;
            in_sample = w;
        end while (!in_ready);
        model_add(w);
    endtask

    task automatic receive_result(input sparam_set_t expected);
        int        stall;
        wave_set_t junk;
        @(negedge clk_in);
        in_valid = 1'b0;
        while (!out_valid) begin
            @(negedge clk_in);
        end
        check_handshake(1'b0, 1'b1);
        check_sparams(expected);
        // consumer stalls while samples are offered and must be ignored
        stall = int'(random_bits(4));
        for (int i = 0; i < stall; i++) begin
            make_sample(MODE_NORMAL, junk);
            in_valid  = 1'b1;
            in_sample = junk;
            @(negedge clk_in);
            check_handshake(1'b0, 1'b1);
            check_sparams(expected);
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        @(negedge clk_in);
        out_ready = 1'b0;
        check_handshake(1'b1, 1'b0);
    endtask

    task automatic run_block(input int mode);
        sparam_set_t expected;
        model_sums = '0;
        for (int k = 0; k < int'(num_samples); k++) begin
            send_sample(mode);
        end
        expected = expect_result(model_sums, num_samples);
        receive_result(expected);
    endtask

    // full block up to a held result, then reset drops it
    task automatic reset_during_output();
        for (int k = 0; k < int'(num_samples); k++) begin
            send_sample(MODE_NORMAL);
        end
        @(negedge clk_in);
        in_valid = 1'b0;
        while (!out_valid) begin
            @(negedge clk_in);
        end
        apply_reset(num_samples);
    endtask

    // partial block, then reset drops it
    task automatic abandon_block();
        int count;
        count = 0;
        if (num_samples > 16'd1) begin
            count = 1 + int'(random_bits(3)) % (int'(num_samples) - 1);
        end
        for (int k = 0; k < count; k++) begin
            send_sample(MODE_NORMAL);
        end
        apply_reset(num_samples);
    endtask

    initial begin
        logic [15:0] prev_n;
        logic [15:0] next_n;
        lfsr_state  = 16'd83;
        rst_in      = 1'b1;
        in_valid    = 1'b0;
        in_sample   = '0;
        out_ready   = 1'b0;
        num_samples = 16'd1;
        model_sums  = '0;
        prev_n      = '0;

        for (int run = 0; run < NUM_RUNS; run++) begin
            do begin
                next_n = 16'(random_bits(3)) + 16'd1;
            end while (next_n == prev_n);
            prev_n = next_n;
            apply_reset(next_n);

            run_block(MODE_NORMAL);
            run_block(MODE_NORMAL);
            run_block(MODE_ZERO_A1);
            run_block(MODE_WRAP);
            reset_during_output();
            abandon_block();
            run_block(MODE_NORMAL);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sparam_properties.sv ====
module sparam_properties import sparam_pkg::*; (
    input logic        clk_in,
    input logic        rst_in,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input sparam_set_t out_sparams
);

    // result held while the consumer stalls
    property hold_while_stalled;
        @(posedge clk_in) disable iff (rst_in)
            (out_valid && !out_ready) |=> $stable(out_sparams);
    endproperty

    property no_accept_during_output;
        @(posedge clk_in) disable iff (rst_in)
            !(in_ready && out_valid);
    endproperty

    property idle_after_reset;
        @(posedge clk_in) rst_in |=> !out_valid;
    endproperty

    assert property (hold_while_stalled)
        else $error("out_sparams changed while out_valid high and out_ready low");

    assert property (no_accept_during_output)
        else $error("in_ready and out_valid high together");

    assert property (idle_after_reset)
        else $error("out_valid high in the cycle after reset");

endmodule

bind sparam_averager_top sparam_properties sparam_properties_i (.*);

// ==== sparam_averager_top.sv ====
module sparam_averager_top import sparam_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic [15:0] num_samples,
    input  logic        in_valid,
    input  wave_set_t   in_sample,
    input  logic        out_ready,
    output logic        in_ready,
    output logic        out_valid,
    output sparam_set_t out_sparams
);

    block_sums_t                        sums;
    logic                               block_done;
    logic                               clear;

    logic [NUM_DIVIDERS-1:0][ACC_W-1:0] div_dividend;
    logic [NUM_DIVIDERS-1:0][ACC_W-1:0] div_divisor;
    logic [NUM_DIVIDERS-1:0][ACC_W-1:0] div_quotient;
    logic                               div_start;
    logic [NUM_DIVIDERS-1:0]            div_done_bus;
    logic [NUM_DIVIDERS-1:0]            div_by_zero_bus;

    sample_accumulator sample_accumulator_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .num_samples (num_samples),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_sample   (in_sample),
        .clear       (clear),
        .sums        (sums),
        .block_done  (block_done)
    );

    // all dividers start together and finish on the same edge
    sparam_sequencer sparam_sequencer_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .num_samples  (num_samples),
        .sums         (sums),
        .block_done   (block_done),
        .out_ready    (out_ready),
        .div_quotient (div_quotient),
        .div_done     (div_done_bus[0]),
        .div_by_zero  (div_by_zero_bus[3:0]),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_start    (div_start),
        .in_ready     (in_ready),
        .clear        (clear),
        .out_valid    (out_valid),
        .out_sparams  (out_sparams)
    );

    for (genvar g = 0; g < NUM_DIVIDERS; g++) begin : g_div
        seq_divider seq_divider_i (
            .clk_in      (clk_in),
            .rst_in      (rst_in),
            .dividend    (div_dividend[g]),
            .divisor     (div_divisor[g]),
            .start       (div_start),
            .quotient    (div_quotient[g]),
            .done        (div_done_bus[g]),
            .div_by_zero (div_by_zero_bus[g])
        );
    end

endmodule

// ==== sparam_sequencer.sv ====
module sparam_sequencer import sparam_pkg::*; (
    input  logic                               clk_in,
    input  logic                               rst_in,
    input  logic [15:0]                        num_samples,
    input  block_sums_t                        sums,
    input  logic                               block_done,
    input  logic                               out_ready,
    input  logic [NUM_DIVIDERS-1:0][ACC_W-1:0] div_quotient,
    input  logic                               div_done,
    input  logic [3:0]                         div_by_zero,
    output logic [NUM_DIVIDERS-1:0][ACC_W-1:0] div_dividend,
    output logic [NUM_DIVIDERS-1:0][ACC_W-1:0] div_divisor,
    output logic                               div_start,
    output logic                               in_ready,
    output logic                               clear,
    output logic                               out_valid,
    output sparam_set_t                        out_sparams
);

    seq_state_t                 state;

    // means of the block, index 0..3 is s11, s12, s21, s22 for phase
    // and a1, b1, a2, b2 for radius
    logic [3:0][COEFF_W-1:0]    mean_phase;
    logic [3:0][ACC_W-1:0]      mean_rad;
    logic [3:0][ACC_W-1:0]      mag_sel;

    // the cycle after the last sample still sits in ACCUMULATE
    assign in_ready  = (state == ACCUMULATE) && !block_done;
    assign out_valid = (state == HOLD_OUTPUT);
    // acts on the same edge that leaves HOLD_OUTPUT
    assign clear     = (state == HOLD_OUTPUT) && out_ready;

    // zero mean a gives magnitude 0
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mag_sel[i] = div_by_zero[i] ? '0 : div_quotient[i];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= ACCUMULATE;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                ACCUMULATE: begin
                    if (block_done) begin
                        state <= START_AVERAGE;
                    end
                end
                START_AVERAGE: begin
                    div_start <= 1'b1;
                    state     <= WAIT_AVERAGE;
                end
                WAIT_AVERAGE: begin
                    if (div_done) begin
                        state <= START_RATIO;
                    end
                end
                START_RATIO: begin
                    div_start <= 1'b1;
                    state     <= WAIT_RATIO;
                end
                WAIT_RATIO: begin
                    if (div_done) begin
                        state <= HOLD_OUTPUT;
                    end
                end
                HOLD_OUTPUT: begin
                    if (out_ready) begin
                        state <= ACCUMULATE;
                    end
                end
                default: state <= ACCUMULATE;
            endcase
        end
    end

    // operands, means and result
    always_ff @(posedge clk_in) begin
        case (state)
            START_AVERAGE: begin
                div_dividend[0] <= sums.ang_s11;
                div_dividend[1] <= sums.ang_s12;
                div_dividend[2] <= sums.ang_s21;
                div_dividend[3] <= sums.ang_s22;
                div_dividend[4] <= sums.rad_a1;
                div_dividend[5] <= sums.rad_b1;
                div_dividend[6] <= sums.rad_a2;
                div_dividend[7] <= sums.rad_b2;
                for (int i = 0; i < NUM_DIVIDERS; i++) begin
                    div_divisor[i] <= ACC_W'(num_samples);
                end
            end
            WAIT_AVERAGE: begin
                if (div_done) begin
                    for (int i = 0; i < 4; i++) begin
                        mean_phase[i] <= div_quotient[i][COEFF_W-1:0];
                        mean_rad[i]   <= div_quotient[i+4];
                    end
                end
            end
            START_RATIO: begin
                // b1/a1, b1/a2, b2/a1, b2/a2
                div_dividend[0] <= mean_rad[1] << RATIO_FRAC_BITS;
                div_divisor[0]  <= mean_rad[0];
                div_dividend[1] <= mean_rad[1] << RATIO_FRAC_BITS;
                div_divisor[1]  <= mean_rad[2];
                div_dividend[2] <= mean_rad[3] << RATIO_FRAC_BITS;
                div_divisor[2]  <= mean_rad[0];
                div_dividend[3] <= mean_rad[3] << RATIO_FRAC_BITS;
                div_divisor[3]  <= mean_rad[2];
            end
            WAIT_RATIO: begin
                if (div_done) begin
                    out_sparams.s11 <= '{phase: mean_phase[0], mag: mag_sel[0]};
                    out_sparams.s12 <= '{phase: mean_phase[1], mag: mag_sel[1]};
                    out_sparams.s21 <= '{phase: mean_phase[2], mag: mag_sel[2]};
                    out_sparams.s22 <= '{phase: mean_phase[3], mag: mag_sel[3]};
                end
            end
            default: begin
                // hold everything
            end
        endcase
    end

endmodule

// ==== sample_accumulator.sv ====
module sample_accumulator import sparam_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic [15:0] num_samples,
    input  logic        in_valid,
    input  logic        in_ready,
    input  wave_set_t   in_sample,
    input  logic        clear,
    output block_sums_t sums,
    output logic        block_done
);

    logic [15:0]        count;
    logic               take;
    logic               last_sample;
    logic [COEFF_W-1:0] diff_s11;
    logic [COEFF_W-1:0] diff_s12;
    logic [COEFF_W-1:0] diff_s21;
    logic [COEFF_W-1:0] diff_s22;

    assign take        = in_valid && in_ready;
    assign last_sample = (count == num_samples - 16'd1);

    // angle differences wrap modulo 2^16
    assign diff_s11 = in_sample.b1.angle - in_sample.a1.angle;
    assign diff_s12 = in_sample.b1.angle - in_sample.a2.angle;
    assign diff_s21 = in_sample.b2.angle - in_sample.a1.angle;
    assign diff_s22 = in_sample.b2.angle - in_sample.a2.angle;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count      <= '0;
            sums       <= '0;
            block_done <= 1'b0;
        end else begin
            block_done <= 1'b0;
            if (clear) begin
                count <= '0;
                sums  <= '0;
            end else if (take) begin
                if (last_sample) begin
                    count      <= '0;
                    block_done <= 1'b1;
                end else begin
                    count <= count + 16'd1;
                end

                sums.rad_a1  <= sums.rad_a1 + ACC_W'(in_sample.a1.radius);
                sums.rad_b1  <= sums.rad_b1 + ACC_W'(in_sample.b1.radius);
                sums.rad_a2  <= sums.rad_a2 + ACC_W'(in_sample.a2.radius);
                sums.rad_b2  <= sums.rad_b2 + ACC_W'(in_sample.b2.radius);

                // zero-extended before summing
                sums.ang_s11 <= sums.ang_s11 + ACC_W'(diff_s11);
                sums.ang_s12 <= sums.ang_s12 + ACC_W'(diff_s12);
                sums.ang_s21 <= sums.ang_s21 + ACC_W'(diff_s21);
                sums.ang_s22 <= sums.ang_s22 + ACC_W'(diff_s22);
            end
        end
    end

endmodule

// ==== seq_divider.sv ====
module seq_divider import sparam_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic [ACC_W-1:0] dividend,
    input  logic [ACC_W-1:0] divisor,
    input  logic             start,
    output logic [ACC_W-1:0] quotient,
    output logic             done,
    output logic             div_by_zero
);

    typedef enum logic {
        DIV_REST,
        DIV_RUN
    } div_state_t;

    div_state_t             state;
    logic [DIV_COUNT_W-1:0] bit_count;
    // dividend bits shift out of the top while quotient bits shift in below
    logic [ACC_W-1:0]       work;
    logic [ACC_W-1:0]       divisor_q;
    logic [ACC_W-1:0]       rem;
    // one extra bit so a large divisor cannot overflow the trial
    logic [ACC_W:0]         trial;
    logic                   last_bit;

    assign trial    = {rem, work[ACC_W-1]};
    assign last_bit = (bit_count == DIV_COUNT_W'(ACC_W));
    assign quotient = work;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= DIV_REST;
            bit_count   <= '0;
            done        <= 1'b0;
            div_by_zero <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DIV_REST: begin
                    if (start) begin
                        state       <= DIV_RUN;
                        bit_count   <= '0;
                        div_by_zero <= (divisor == '0);
                    end
                end
                DIV_RUN: begin
                    // 32 shift edges, then one edge to report
                    if (last_bit) begin
                        state <= DIV_REST;
                        done  <= 1'b1;
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end
                default: state <= DIV_REST;
            endcase
        end
    end

    // restoring step, one quotient bit per edge
    always_ff @(posedge clk_in) begin
        if (state == DIV_REST) begin
            if (start) begin
                work      <= dividend;
                divisor_q <= divisor;
                rem       <= '0;
            end
        end else if (!last_bit) begin
            if (trial >= {1'b0, divisor_q}) begin
                rem  <= ACC_W'(trial - {1'b0, divisor_q});
                work <= {work[ACC_W-2:0], 1'b1};
            end else begin
                rem  <= trial[ACC_W-1:0];
                work <= {work[ACC_W-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== sparam_pkg.sv ====
package sparam_pkg;

    // coefficient and arithmetic widths
    localparam int COEFF_W         = 16;
    localparam int ACC_W           = 32;
    localparam int RATIO_FRAC_BITS = 16;

    // divider bank
    localparam int NUM_DIVIDERS    = 8;
    localparam int DIV_COUNT_W     = 6;

    // one measured wave coefficient
    typedef struct packed {
        logic [COEFF_W-1:0] angle;
        logic [COEFF_W-1:0] radius;
    } coeff_t;

    // one input sample, all four waves
    typedef struct packed {
        coeff_t a1;
        coeff_t b1;
        coeff_t a2;
        coeff_t b2;
    } wave_set_t;

    // running sums of one block
    typedef struct packed {
        logic [ACC_W-1:0] rad_a1;
        logic [ACC_W-1:0] rad_b1;
        logic [ACC_W-1:0] rad_a2;
        logic [ACC_W-1:0] rad_b2;
        logic [ACC_W-1:0] ang_s11;
        logic [ACC_W-1:0] ang_s12;
        logic [ACC_W-1:0] ang_s21;
        logic [ACC_W-1:0] ang_s22;
    } block_sums_t;

    // one s-parameter, mag is fixed point with RATIO_FRAC_BITS fraction
    typedef struct packed {
        logic [COEFF_W-1:0] phase;
        logic [ACC_W-1:0]   mag;
    } sparam_t;

    typedef struct packed {
        sparam_t s11;
        sparam_t s12;
        sparam_t s21;
        sparam_t s22;
    } sparam_set_t;

    typedef enum logic [2:0] {
        ACCUMULATE,
        START_AVERAGE,
        WAIT_AVERAGE,
        START_RATIO,
        WAIT_RATIO,
        HOLD_OUTPUT
    } seq_state_t;

endpackage
